/* hdl/eth_encap_pkg.sv */
// protocol constants, widths and shared stream and lookup types for the DNS guard
package eth_encap_pkg;

	localparam int DATA_W       = 64;
	localparam int KEEP_W       = 8;
	localparam int KEY_W        = 96;
	localparam int FLAG_W       = 4;
	localparam int BEAT_CNT_W   = 10;
	localparam int DELAY_STAGES = 12;

	localparam logic [15:0] ETH_FTYPE_IP      = 16'h0800;
	localparam logic [7:0]  IP_PROTO_UDP      = 8'h11;
	localparam logic [7:0]  IP_PROTO_ICMP     = 8'h01;
	localparam logic [7:0]  ICMP_DEST_UNREACH = 8'h03;
	localparam logic [7:0]  ICMP_PORT_UNREACH = 8'h03;
	localparam logic [7:0]  ICMP_ADMIN_PROHIB = 8'h0a;
	localparam logic [15:0] DNS_SERV_PORT     = 16'd53;

	// reply status lives in flag bits 2:1
	localparam logic [1:0]        STATUS_ARREST = 2'b10;
	localparam logic [FLAG_W-1:0] OP_SUSPECT    = 4'b0000;
	localparam logic [FLAG_W-1:0] OP_FILTER     = 4'b0101;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] data;
		logic [KEEP_W-1:0] keep;
		logic              last;
	} axis_beat_t;

	typedef struct packed {
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] dst_port;
		logic [15:0] pad;
	} flow_key_t;

	typedef struct packed {
		logic              valid;
		flow_key_t         key;
		logic [FLAG_W-1:0] flag;
	} lookup_req_t;

endpackage

/* hdl/dns_reply_parser.sv */
// port 0 beat counter, Ethernet/IP/UDP field extraction and DNS response lookup request
`timescale 1ns/1ps

module dns_reply_parser import eth_encap_pkg::*; (
	input  logic        clk156,
	input  logic        eth_rst,
	input  axis_beat_t  rx,
	output lookup_req_t req,
	output logic        frame_start
);

	logic [BEAT_CNT_W-1:0] beat_cnt;
	// byte 0 moved to the top lane, so fields read in network order
	logic [DATA_W-1:0] net_data;
	logic [15:0] ftype;
	logic [7:0]  ip_proto;
	logic [31:0] src_ip;
	logic [31:0] dst_ip;
	logic [15:0] src_port;
	logic [15:0] dst_port;
	logic        is_udp;
	logic        fire;

	assign net_data = {<<8{rx.data}};
	assign is_udp   = (ftype == ETH_FTYPE_IP) && (ip_proto == IP_PROTO_UDP);
	// request goes out after the beat that carries the DNS flags word
	assign fire     = rx.valid && (beat_cnt == BEAT_CNT_W'(6)) && is_udp &&
		(src_port == DNS_SERV_PORT);

	// saturates on oversized frames instead of wrapping to beat 0
	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			beat_cnt <= '0;
		end else if (rx.valid) begin
			if (rx.last)
				beat_cnt <= '0;
			else if (beat_cnt != '1)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk156) begin
		if (rx.valid) begin
			case (int'(beat_cnt))
				0: begin
					ftype    <= '0;
					ip_proto <= '0;
					src_ip   <= '0;
					dst_ip   <= '0;
					src_port <= '0;
					dst_port <= '0;
				end
				1: ftype <= net_data[31:16];
				2: ip_proto <= net_data[7:0];
				3: begin
					src_ip        <= net_data[47:16];
					dst_ip[31:16] <= net_data[15:0];
				end
				4: begin
					dst_ip[15:0] <= net_data[63:48];
					if (is_udp) begin
						src_port <= net_data[47:32];
						dst_port <= net_data[31:16];
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			req         <= '0;
			frame_start <= 1'b0;
		end else begin
			frame_start <= rx.valid && (beat_cnt == '0);
			req.valid   <= fire;
			if (fire) begin
				req.key  <= '{src_ip: src_ip, dst_ip: dst_ip, dst_port: dst_port, pad: '0};
				req.flag <= OP_SUSPECT;
			end
		end
	end

endmodule

/* hdl/icmp_unreach_parser.sv */
// port 1 beat counter, ICMP unreachable and quoted UDP header extraction, filter request
`timescale 1ns/1ps

module icmp_unreach_parser import eth_encap_pkg::*; (
	input  logic        clk156,
	input  logic        eth_rst,
	input  axis_beat_t  rx,
	output lookup_req_t req
);

	logic [BEAT_CNT_W-1:0] beat_cnt;
	logic [DATA_W-1:0] net_data;
	logic [15:0] ftype;
	logic [7:0]  ip_proto;
	logic [7:0]  icmp_type;
	logic [7:0]  icmp_code;
	// header of the offending datagram, quoted inside the ICMP body
	logic [31:0] q_src_ip;
	logic [31:0] q_dst_ip;
	logic [15:0] q_src_port;
	logic [15:0] q_dst_port;
	logic        is_icmp;
	logic        unreach;
	logic        fire;

	assign net_data = {<<8{rx.data}};
	assign is_icmp  = (ftype == ETH_FTYPE_IP) && (ip_proto == IP_PROTO_ICMP);
	assign unreach  = is_icmp && (icmp_type == ICMP_DEST_UNREACH) &&
		((icmp_code == ICMP_PORT_UNREACH) || (icmp_code == ICMP_ADMIN_PROHIB));
	assign fire     = rx.valid && (beat_cnt == BEAT_CNT_W'(10)) && unreach &&
		(q_src_port == DNS_SERV_PORT);

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			beat_cnt <= '0;
		end else if (rx.valid) begin
			if (rx.last)
				beat_cnt <= '0;
			else if (beat_cnt != '1)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk156) begin
		if (rx.valid) begin
			case (int'(beat_cnt))
				0: begin
					ftype      <= '0;
					ip_proto   <= '0;
					icmp_type  <= '0;
					icmp_code  <= '0;
					q_src_ip   <= '0;
					q_dst_ip   <= '0;
					q_src_port <= '0;
					q_dst_port <= '0;
				end
				1: ftype <= net_data[31:16];
				2: ip_proto <= net_data[7:0];
				4: begin
					if (is_icmp) begin
						icmp_type <= net_data[47:40];
						icmp_code <= net_data[39:32];
					end
				end
				6: q_src_ip[31:16] <= net_data[15:0];
				7: begin
					q_src_ip[15:0] <= net_data[63:48];
					q_dst_ip       <= net_data[47:16];
					q_src_port     <= net_data[15:0];
				end
				8: q_dst_port <= net_data[63:48];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			req <= '0;
		end else begin
			req.valid <= fire;
			if (fire) begin
				req.key  <= '{src_ip: q_src_ip, dst_ip: q_dst_ip, dst_port: q_dst_port,
					pad: '0};
				req.flag <= OP_FILTER;
			end
		end
	end

endmodule

/* hdl/lookup_arbiter.sv */
// request merge onto the flow table port with port 0 priority, arrest reply block latch
`timescale 1ns/1ps

module lookup_arbiter import eth_encap_pkg::*; (
	input  logic              clk156,
	input  logic              eth_rst,
	input  lookup_req_t       suspect_req,
	input  lookup_req_t       filter_req,
	input  logic              frame_start,
	input  logic              out_valid,
	input  logic [FLAG_W-1:0] out_flag,
	output lookup_req_t       lookup,
	output logic              block
);

	lookup_req_t pending;
	logic        arrest;
	logic        blocked;

	assign arrest = out_valid && (out_flag[2:1] == STATUS_ARREST);
	// active in the reply cycle itself, held by the latch afterwards
	assign block  = arrest || blocked;

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			lookup  <= '0;
			pending <= '0;
		end else if (suspect_req.valid) begin
			lookup <= suspect_req;
			// port 1 waits one cycle
			if (filter_req.valid)
				pending <= filter_req;
		end else if (pending.valid) begin
			lookup  <= pending;
			pending <= filter_req;
		end else begin
			lookup <= filter_req;
		end
	end

	// next port 0 frame releases the block
	always_ff @(posedge clk156) begin
		if (eth_rst)
			blocked <= 1'b0;
		else if (frame_start)
			blocked <= 1'b0;
		else if (arrest)
			blocked <= 1'b1;
	end

endmodule

/* hdl/frame_delay.sv */
// port 0 delay line that holds traffic for the lookup verdict and zeroes it under block
`timescale 1ns/1ps

module frame_delay import eth_encap_pkg::*; (
	input  logic       clk156,
	input  logic       eth_rst,
	input  logic       block,
	input  axis_beat_t din,
	output axis_beat_t dout
);

	axis_beat_t stage [DELAY_STAGES];

	always_ff @(posedge clk156) begin
		if (eth_rst) begin
			for (int i = 0; i < DELAY_STAGES; i++)
				stage[i] <= '0;
		end else begin
			// input stage keeps loading even while blocked
			stage[0] <= din;
			for (int i = 1; i < DELAY_STAGES; i++) begin
				if (block)
					stage[i] <= '0;
				else
					stage[i] <= stage[i-1];
			end
		end
	end

	assign dout = stage[DELAY_STAGES-1];

endmodule

/* hdl/eth_encap.sv */
// top level of the DNS reflection guard, parsers, lookup arbiter and port 0 delay line
`timescale 1ns/1ps

module eth_encap import eth_encap_pkg::*; (
	input  logic              clk156,
	input  logic              eth_rst,

	input  logic              s_axis_rx0_tvalid,
	input  logic [DATA_W-1:0] s_axis_rx0_tdata,
	input  logic [KEEP_W-1:0] s_axis_rx0_tkeep,
	input  logic              s_axis_rx0_tlast,

	input  logic              s_axis_rx1_tvalid,
	input  logic [DATA_W-1:0] s_axis_rx1_tdata,
	input  logic              s_axis_rx1_tlast,

	output logic              m_axis_tx1_tvalid,
	output logic [DATA_W-1:0] m_axis_tx1_tdata,
	output logic [KEEP_W-1:0] m_axis_tx1_tkeep,
	output logic              m_axis_tx1_tlast,

	output logic [KEY_W-1:0]  in_key,
	output logic [FLAG_W-1:0] in_flag,
	output logic              in_valid,
	input  logic              out_valid,
	input  logic [FLAG_W-1:0] out_flag
);

	axis_beat_t  rx0_beat;
	axis_beat_t  rx1_beat;
	axis_beat_t  tx1_beat;
	lookup_req_t suspect_req;
	lookup_req_t filter_req;
	lookup_req_t lookup;
	logic        frame_start;
	logic        block;

	assign rx0_beat = '{valid: s_axis_rx0_tvalid, data: s_axis_rx0_tdata,
		keep: s_axis_rx0_tkeep, last: s_axis_rx0_tlast};
	// port 1 carries no keep
	assign rx1_beat = '{valid: s_axis_rx1_tvalid, data: s_axis_rx1_tdata,
		keep: '0, last: s_axis_rx1_tlast};

	dns_reply_parser u_dns_reply_parser (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.rx          (rx0_beat),
		.req         (suspect_req),
		.frame_start (frame_start)
	);

	icmp_unreach_parser u_icmp_unreach_parser (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.rx      (rx1_beat),
		.req     (filter_req)
	);

	lookup_arbiter u_lookup_arbiter (
		.clk156      (clk156),
		.eth_rst     (eth_rst),
		.suspect_req (suspect_req),
		.filter_req  (filter_req),
		.frame_start (frame_start),
		.out_valid   (out_valid),
		.out_flag    (out_flag),
		.lookup      (lookup),
		.block       (block)
	);

	frame_delay u_frame_delay (
		.clk156  (clk156),
		.eth_rst (eth_rst),
		.block   (block),
		.din     (rx0_beat),
		.dout    (tx1_beat)
	);

	assign m_axis_tx1_tvalid = tx1_beat.valid;
	assign m_axis_tx1_tdata  = tx1_beat.data;
	assign m_axis_tx1_tkeep  = tx1_beat.keep;
	assign m_axis_tx1_tlast  = tx1_beat.last;

	assign in_valid = lookup.valid;
	assign in_key   = lookup.key;
	assign in_flag  = lookup.flag;

endmodule

/* tb/eth_encap_properties.sv */
// bound concurrent assertions on the lookup port and tx1 stream of the top level
`timescale 1ns/1ps

module eth_encap_properties import eth_encap_pkg::*; (
	input logic              clk156,
	input logic              eth_rst,
	input logic              in_valid,
	input logic [FLAG_W-1:0] in_flag,
	input logic              m_axis_tx1_tvalid,
	input logic              m_axis_tx1_tlast
);

	// only the two request kinds reach the flow table
	flag_known: assert property (@(posedge clk156) disable iff (eth_rst)
		in_valid |-> (in_flag == OP_SUSPECT || in_flag == OP_FILTER))
		else $error("lookup request with unknown flag");

	last_has_valid: assert property (@(posedge clk156) disable iff (eth_rst)
		m_axis_tx1_tlast |-> m_axis_tx1_tvalid)
		else $error("tx1 tlast without tvalid");

	quiet_in_reset: assert property (@(posedge clk156)
		eth_rst |=> (!in_valid && !m_axis_tx1_tvalid))
		else $error("output active during reset");

endmodule

bind eth_encap eth_encap_properties u_props (
	.clk156            (clk156),
	.eth_rst           (eth_rst),
	.in_valid          (in_valid),
	.in_flag           (in_flag),
	.m_axis_tx1_tvalid (m_axis_tx1_tvalid),
	.m_axis_tx1_tlast  (m_axis_tx1_tlast)
);

/* tb/eth_encap_tb.sv */
// testbench for the DNS guard with seeded frame generator, flow table responder and reference model
`timescale 1ns/1ps

module eth_encap_tb import eth_encap_pkg::*; ();

	localparam int N_P0  = 20;
	localparam int N_P1  = 20;
	localparam int N_COL = 6;
	localparam int N_BLK = 24;
	// worst case beats per frame incl. gap, per test, plus reset and drain margin
	localparam int TIMEOUT_CYCLES = N_P0 * 13 + N_P1 * 16 + N_COL * 36 + N_BLK * 13 + 400;

	typedef struct packed {
		axis_beat_t b;
		logic       first;
		logic       fire;
		flow_key_t  key;
	} tb_beat_t;

	logic              clk156 = 1'b0;
	logic              eth_rst;
	logic              s_axis_rx0_tvalid, s_axis_rx0_tlast;
	logic [DATA_W-1:0] s_axis_rx0_tdata;
	logic [KEEP_W-1:0] s_axis_rx0_tkeep;
	logic              s_axis_rx1_tvalid, s_axis_rx1_tlast;
	logic [DATA_W-1:0] s_axis_rx1_tdata;
	logic              m_axis_tx1_tvalid, m_axis_tx1_tlast;
	logic [DATA_W-1:0] m_axis_tx1_tdata;
	logic [KEEP_W-1:0] m_axis_tx1_tkeep;
	logic [KEY_W-1:0]  in_key;
	logic [FLAG_W-1:0] in_flag;
	logic              in_valid;
	logic              out_valid;
	logic [FLAG_W-1:0] out_flag;

	integer      seed = 32374;
	int          errors = 0;
	int          checks = 0;
	int          test_start = 0;
	int          cycles = 0;
	int          reply_wait = 0;
	logic        reply_arrest = 1'b0;
	logic        arrest_en = 1'b0;
	tb_beat_t    q0[$];
	tb_beat_t    q1[$];
	tb_beat_t    cur0 = '0;
	tb_beat_t    cur1 = '0;
	// reference model state
	axis_beat_t  dl [DELAY_STAGES];
	lookup_req_t arb_q[$];
	lookup_req_t p_s = '0;
	lookup_req_t p_f = '0;
	lookup_req_t m_look = '0;
	logic        m_blocked = 1'b0;
	logic        m_fs = 1'b0;
	logic        arrest_m;
	logic        blk_m;

	eth_encap uut (.*);

	always #20 clk156 = ~clk156;

	always @(posedge clk156) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [127:0] exp, input logic [127:0] act);
		checks++;
		if (exp !== act) begin
			$display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, exp, act);
			errors++;
		end
	endtask

	// frame bytes laid out at Ethernet offsets, byte 0 in lane 0
	task automatic push_frame(input int port, input int kind);
		byte unsigned fr[128];
		int           nb;
		int           fire_beat;
		logic         fire;
		flow_key_t    key;
		tb_beat_t     e;
		nb = (port == 0 ? 8 : 11) + int'({$random(seed)} % 4);
		for (int i = 0; i < 128; i++)
			fr[i] = 8'($random(seed));
		fr[12] = 8'h08;
		fr[13] = 8'h00;
		if (port == 0) begin
			fire_beat = 6;
			fr[23] = IP_PROTO_UDP;
			fr[34] = (kind == 1) ? 8'h10 : 8'h00;
			fr[35] = 8'd53;
			if (kind == 2) begin
				fr[12] = 8'h86;
				fr[13] = 8'hdd;
			end
			fire = (kind == 0);
			key = '{src_ip: {fr[26], fr[27], fr[28], fr[29]},
				dst_ip: {fr[30], fr[31], fr[32], fr[33]}, dst_port: {fr[36], fr[37]}, pad: '0};
		end else begin
			fire_beat = 10;
			fr[23] = IP_PROTO_ICMP;
			fr[34] = 8'd3;
			fr[35] = (kind == 1) ? 8'd10 : (kind == 2) ? 8'd0 : 8'd3;
			fr[62] = (kind == 3) ? 8'h10 : 8'h00;
			fr[63] = 8'd53;
			fire = (kind < 2);
			key = '{src_ip: {fr[54], fr[55], fr[56], fr[57]},
				dst_ip: {fr[58], fr[59], fr[60], fr[61]}, dst_port: {fr[64], fr[65]}, pad: '0};
		end
		for (int k = 0; k < nb; k++) begin
			e = '0;
			e.b.valid = 1'b1;
			for (int j = 0; j < 8; j++)
				e.b.data[8*j +: 8] = fr[8*k + j];
			e.b.last = (k == nb - 1);
			e.b.keep = e.b.last ? (8'hff >> ({$random(seed)} % 8)) : 8'hff;
			e.first = (k == 0);
			e.fire = fire && (k == fire_beat);
			e.key = key;
			if (port == 0)
				q0.push_back(e);
			else
				q1.push_back(e);
		end
		// short idle gap after the frame
		for (int g = 0; g < int'({$random(seed)} % 3); g++) begin
			if (port == 0)
				q0.push_back('0);
			else
				q1.push_back('0);
		end
	endtask

	task automatic drive_beats(input tb_beat_t b0, input tb_beat_t b1);
		cur0 = b0;
		cur1 = b1;
		s_axis_rx0_tvalid = b0.b.valid;
		s_axis_rx0_tdata  = b0.b.data;
		s_axis_rx0_tkeep  = b0.b.keep;
		s_axis_rx0_tlast  = b0.b.last;
		s_axis_rx1_tvalid = b1.b.valid;
		s_axis_rx1_tdata  = b1.b.data;
		s_axis_rx1_tlast  = b1.b.last;
	endtask

	task automatic run_queues();
		tb_beat_t b0;
		tb_beat_t b1;
		while (q0.size() > 0 || q1.size() > 0) begin
			@(posedge clk156);
			#1;
			b0 = (q0.size() > 0) ? q0.pop_front() : '0;
			b1 = (q1.size() > 0) ? q1.pop_front() : '0;
			drive_beats(b0, b1);
		end
		@(posedge clk156);
		#1;
		drive_beats('0, '0);
		// delay line length fixes the drain time
		repeat (DELAY_STAGES + 6) @(posedge clk156);
	endtask

	task automatic end_test(input string name);
		$display("test %-14s %s (%0d errors)", name,
			(errors == test_start) ? "ok" : "failed", errors - test_start);
		test_start = errors;
	endtask

	// flow table responder
	always @(posedge clk156) begin
		#1;
		out_valid = 1'b0;
		if (reply_wait > 0) begin
			reply_wait--;
			if (reply_wait == 0) begin
				out_valid = 1'b1;
				out_flag  = reply_arrest ? 4'b0100 : 4'b0010;
			end
		end
	end

	// compare at the falling edge, then advance the model by the coming rising edge
	always @(negedge clk156) begin
		if (in_valid !== m_look.valid) begin
			$display("lookup request at %0t was %s", $time,
				m_look.valid ? "missing" : "not expected");
			errors++;
		end else if (in_valid) begin
			check_val("in_key", m_look.key, in_key);
			check_val("in_flag", m_look.flag, in_flag);
		end
		check_val("m_axis_tx1_tvalid", dl[DELAY_STAGES-1].valid, m_axis_tx1_tvalid);
		check_val("m_axis_tx1_tdata", dl[DELAY_STAGES-1].data, m_axis_tx1_tdata);
		check_val("m_axis_tx1_tkeep", dl[DELAY_STAGES-1].keep, m_axis_tx1_tkeep);
		check_val("m_axis_tx1_tlast", dl[DELAY_STAGES-1].last, m_axis_tx1_tlast);
		if (in_valid === 1'b1 && reply_wait == 0) begin
			reply_wait   = 1 + int'({$random(seed)} % 4);
			reply_arrest = arrest_en && $random(seed) % 2 == 0;
		end
		if (eth_rst) begin
			for (int i = 0; i < DELAY_STAGES; i++)
				dl[i] = '0;
			arb_q.delete();
			p_s = '0;
			p_f = '0;
			m_look = '0;
			m_blocked = 1'b0;
			m_fs = 1'b0;
		end else begin
			arrest_m = out_valid && (out_flag[2:1] == 2'b10);
			blk_m = arrest_m || m_blocked;
			for (int i = DELAY_STAGES - 1; i > 0; i--)
				dl[i] = blk_m ? '0 : dl[i-1];
			dl[0] = cur0.b;
			m_blocked = m_fs ? 1'b0 : (arrest_m ? 1'b1 : m_blocked);
			m_fs = cur0.b.valid && cur0.first;
			// port 0 request queued ahead of port 1, one request per cycle
			if (p_s.valid)
				arb_q.push_back(p_s);
			if (p_f.valid)
				arb_q.push_back(p_f);
			m_look = (arb_q.size() > 0) ? arb_q.pop_front() : '0;
			p_s = '0;
			p_f = '0;
			if (cur0.b.valid && cur0.fire)
				p_s = '{valid: 1'b1, key: cur0.key, flag: OP_SUSPECT};
			if (cur1.b.valid && cur1.fire)
				p_f = '{valid: 1'b1, key: cur1.key, flag: OP_FILTER};
		end
	end

	initial begin
		eth_rst = 1'b1;
		out_valid = 1'b0;
		out_flag = '0;
		drive_beats('0, '0);
		for (int i = 0; i < DELAY_STAGES; i++)
			dl[i] = '0;
		repeat (2) @(posedge clk156);
		#1;
		eth_rst = 1'b0;
		repeat (4) @(posedge clk156);
		end_test("reset_idle");
		repeat (N_P0) push_frame(0, int'({$random(seed)} % 3));
		run_queues();
		end_test("port0_passthru");
		repeat (N_P1) push_frame(1, int'({$random(seed)} % 4));
		run_queues();
		end_test("port1_icmp");
		// port 1 starts 4 beats early so beat 10 meets port 0 beat 6
		for (int r = 0; r < N_COL; r++) begin
			while (q0.size() < q1.size())
				q0.push_back('0);
			while (q1.size() < q0.size())
				q1.push_back('0);
			repeat (4) q0.push_back('0);
			push_frame(0, 0);
			push_frame(1, r % 2);
		end
		run_queues();
		end_test("collision");
		arrest_en = 1'b1;
		repeat (N_BLK) push_frame(0, ($random(seed) % 4 == 0) ? 1 : 0);
		run_queues();
		end_test("arrest_block");
		$display("checks=%0d errors=%0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* eth_encap.f */
hdl/eth_encap_pkg.sv
hdl/dns_reply_parser.sv
hdl/icmp_unreach_parser.sv
hdl/lookup_arbiter.sv
hdl/frame_delay.sv
hdl/eth_encap.sv
tb/eth_encap_properties.sv
tb/eth_encap_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the eth_encap testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module eth_encap_tb -f eth_encap.f -o eth_encap_sim

./obj_dir/eth_encap_sim > sim.log 2>&1 || true
cat sim.log

grep -q "Done: no errors" sim.log
echo "simulation passed"
